//--- cache_geom_pkg.sv
package cache_geom_pkg;

	// ************************************************************
	// byte address layout  tag 15..10  index 9..4  word 3..1  byte 0
	// ************************************************************

	localparam int ADDR_W = 16; // cpu byte address width

	localparam int TAG_W   = 6; // upper bits kept per set
	localparam int INDEX_W = 6; // selects one of the sets

	localparam int NUM_SETS = 1 << INDEX_W; // direct mapped, one block per set

	localparam int WORDS_PER_BLOCK = 8; // 16 bit words in a block
	localparam int OFFSET_W        = 4; // byte offset inside a block

	// word select inside a block, byte bit 0 is dropped
	localparam int WORD_OFF_W = $clog2(WORDS_PER_BLOCK);
	localparam int WORD_LSB   = 1; // lowest bit of the word offset

	localparam int TAG_LSB   = 10; // lowest tag bit
	localparam int INDEX_LSB = 4;  // lowest index bit

	// the fields have to tile the address exactly
	// OFFSET_W == WORD_OFF_W + WORD_LSB
	// INDEX_LSB == OFFSET_W
	// TAG_LSB == INDEX_LSB + INDEX_W
	// ADDR_W == TAG_LSB + TAG_W

endpackage

//--- mem_pkg.sv
package mem_pkg;

	// main memory is word organised behind the byte addressed cache
	localparam int WORD_W = 16; // data word width, same on cpu and memory side

	// only the low word address bits are decoded
	// anything above MEM_ADDR_W aliases back into the array
	localparam int MEM_ADDR_W = 12;
	localparam int MEM_DEPTH  = 1 << MEM_ADDR_W; // 4096 words

	// read latency in cycles from request to returning data
	// the read path is pipelined so this many reads can be outstanding
	localparam int MEM_LATENCY_DEFAULT = 4;

endpackage

//--- cache_fill_fsm.sv
`timescale 1ns/1ns

module cache_fill_fsm (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              miss_detected, // lookup missed while idle
	input  logic                              memory_data_valid, // a read word is returning
	input  logic [cache_geom_pkg::ADDR_W-1:0] miss_addr, // address that missed
	output logic                              busy, // stalls the cpu during a fill
	output logic                              mem_read, // one read request per cycle
	output logic [cache_geom_pkg::ADDR_W-1:0] mem_read_addr,
	output logic                              write_data_array, // fill one word of the block
	output logic [cache_geom_pkg::WORD_OFF_W-1:0] cache_write_block_offset,
	output logic                              write_tag_array, // tag and valid written last
	output logic [cache_geom_pkg::ADDR_W-1:0] base_addr // block aligned miss address
);
	import cache_geom_pkg::*;

	logic [WORD_OFF_W:0]   rd_cnt; // words requested so far, msb is the carry
	logic [WORD_OFF_W-1:0] wr_cnt; // next word slot to fill
	logic [WORD_OFF_W:0]   wr_cnt_inc; // write counter plus one with carry
	logic                  read_done;
	logic                  cache_finish; // high for the single cycle after the last write

	assign read_done  = rd_cnt[WORD_OFF_W]; // carry out means all 8 reads are issued
	assign wr_cnt_inc = {1'b0, wr_cnt} + 1'b1;

	// ************************************************************
	// busy flag and base address
	// ************************************************************

	// idle picks up a miss, a running fill holds until the finish cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (busy) begin
			busy <= ~cache_finish;
		end else begin
			busy <= miss_detected;
		end
	end

	// the low offset bits are cleared so the fill starts at word 0 of the block
	always_ff @(posedge clk) begin
		if (!busy && miss_detected) begin
			base_addr <= {miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		end
	end

	// ************************************************************
	// read side, one request per cycle until the carry
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst || cache_finish) begin
			rd_cnt <= '0; // back to word 0 for the next miss
		end else if (mem_read) begin
			rd_cnt <= rd_cnt + 1'b1;
		end
	end

	assign mem_read = busy & ~read_done;

	// byte address of the requested word, stepping by 2 bytes each cycle
	assign mem_read_addr = {base_addr[ADDR_W-1:OFFSET_W], rd_cnt[WORD_OFF_W-1:0],
		{WORD_LSB{1'b0}}};

	// ************************************************************
	// write side, one slot per returning word
	// ************************************************************

	// memory returns words in order, so a plain counter tracks the slot
	always_ff @(posedge clk) begin
		if (rst || cache_finish) begin
			wr_cnt       <= '0;
			cache_finish <= 1'b0;
		end else if (write_data_array) begin
			wr_cnt       <= wr_cnt_inc[WORD_OFF_W-1:0];
			cache_finish <= wr_cnt_inc[WORD_OFF_W]; // sets on the eighth write
		end
	end

	// memory only ever answers the reads of the running fill
	assign write_data_array         = memory_data_valid;
	assign cache_write_block_offset = wr_cnt;

	// the tag goes in only after every word of the block is present
	assign write_tag_array = busy & cache_finish;

endmodule

//--- cache_tag_array.sv
`timescale 1ns/1ns

module cache_tag_array (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              rd, // cpu lookup request
	input  logic                              busy, // fill in progress
	input  logic [cache_geom_pkg::ADDR_W-1:0] addr, // cpu address
	input  logic                              write_tag_array,
	input  logic [cache_geom_pkg::ADDR_W-1:0] fill_addr, // base of the block being filled
	output logic                              hit,
	output logic                              miss_detected
);
	import cache_geom_pkg::*;

	logic [TAG_W-1:0]    tag_mem [NUM_SETS]; // one stored tag per set
	logic [NUM_SETS-1:0] valid; // a set holds a usable block
	logic [INDEX_W-1:0]  rd_index;
	logic [INDEX_W-1:0]  fill_index;
	logic [TAG_W-1:0]    rd_tag;
	logic [TAG_W-1:0]    fill_tag;

	assign rd_index   = addr[INDEX_LSB +: INDEX_W];
	assign rd_tag     = addr[TAG_LSB +: TAG_W];
	assign fill_index = fill_addr[INDEX_LSB +: INDEX_W];
	assign fill_tag   = fill_addr[TAG_LSB +: TAG_W];

	// tag contents only count once the valid bit is set
	always_ff @(posedge clk) begin
		if (write_tag_array) begin
			tag_mem[fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0; // every set starts cold
		end else if (write_tag_array) begin
			valid[fill_index] <= 1'b1;
		end
	end

	assign hit = valid[rd_index] && (tag_mem[rd_index] == rd_tag); // plain match

	// a lookup during a fill is not a new miss
	assign miss_detected = rd & ~busy & ~hit;

endmodule

//--- cache_data_array.sv
`timescale 1ns/1ns

module cache_data_array (
	input  logic                                  clk,
	input  logic [cache_geom_pkg::ADDR_W-1:0]     addr, // cpu read address
	input  logic                                  write_data_array, // fill write strobe
	input  logic [cache_geom_pkg::ADDR_W-1:0]     fill_addr, // block being filled
	input  logic [cache_geom_pkg::WORD_OFF_W-1:0] fill_word, // word slot in that block
	input  logic [mem_pkg::WORD_W-1:0]            fill_data, // word from memory
	output logic [mem_pkg::WORD_W-1:0]            rd_data
);
	import cache_geom_pkg::*;
	import mem_pkg::*;

	// ************************************************************
	// block storage, sets by words
	// ************************************************************

	logic [WORD_W-1:0]     data_mem [NUM_SETS][WORDS_PER_BLOCK];
	logic [INDEX_W-1:0]    rd_index;
	logic [WORD_OFF_W-1:0] rd_word;
	logic [INDEX_W-1:0]    fill_index;

	assign rd_index   = addr[INDEX_LSB +: INDEX_W];
	assign rd_word    = addr[WORD_LSB +: WORD_OFF_W]; // byte bit 0 is ignored
	assign fill_index = fill_addr[INDEX_LSB +: INDEX_W];

	// one word per strobe, the fsm walks fill_word from 0 to 7
	always_ff @(posedge clk) begin
		if (write_data_array) begin
			data_mem[fill_index][fill_word] <= fill_data;
		end
	end

	// read straight out of the array so a hit returns in the same cycle
	// whether the word is meaningful is decided by the tag side
	assign rd_data = data_mem[rd_index][rd_word];

endmodule

//--- main_memory.sv
`timescale 1ns/1ns

module main_memory #(
	parameter int MEM_LATENCY = mem_pkg::MEM_LATENCY_DEFAULT // cycles, 1 or more
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              mem_read, // read request this cycle
	input  logic [cache_geom_pkg::ADDR_W-1:0] mem_read_addr, // byte address
	input  logic                              load, // preload strobe
	input  logic [mem_pkg::MEM_ADDR_W-1:0]    load_addr, // word address
	input  logic [mem_pkg::WORD_W-1:0]        load_data,
	output logic                              mem_data_valid,
	output logic [mem_pkg::WORD_W-1:0]        mem_data
);
	import mem_pkg::*;

	logic [WORD_W-1:0]      mem_array [MEM_DEPTH]; // backing store
	logic [MEM_ADDR_W-1:0]  rd_word; // decoded word address
	logic [MEM_LATENCY-1:0] vld_pipe; // one valid bit per stage
	logic [WORD_W-1:0]      dat_pipe [MEM_LATENCY]; // word travelling with it

	// drop the byte bit, upper address bits fall off and alias
	assign rd_word = mem_read_addr[MEM_ADDR_W:1];

	// ************************************************************
	// load port
	// ************************************************************

	always_ff @(posedge clk) begin
		if (load) begin
			mem_array[load_addr] <= load_data; // one word per cycle
		end
	end

	// ************************************************************
	// read pipeline
	// ************************************************************

	// the array is read when the request arrives, the word then just ages
	// through the stages so a new request can enter every cycle
	always_ff @(posedge clk) begin
		dat_pipe[0] <= mem_array[rd_word];
		for (int i = 1; i < MEM_LATENCY; i++) begin
			dat_pipe[i] <= dat_pipe[i-1];
		end
	end

	// only the valid bits are flushed, stale words are never flagged
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= mem_read;
			for (int i = 1; i < MEM_LATENCY; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
			end
		end
	end

	// last stage shows up MEM_LATENCY cycles after the request
	assign mem_data_valid = vld_pipe[MEM_LATENCY-1];
	assign mem_data       = dat_pipe[MEM_LATENCY-1];

endmodule

//--- cache_subsystem.sv
`timescale 1ns/1ns

module cache_subsystem #(
	parameter int MEM_LATENCY = mem_pkg::MEM_LATENCY_DEFAULT // memory read latency
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              rd, // cpu holds this until ready
	input  logic [cache_geom_pkg::ADDR_W-1:0] addr,
	input  logic                              load, // memory preload, only while rd is low
	input  logic [mem_pkg::MEM_ADDR_W-1:0]    load_addr,
	input  logic [mem_pkg::WORD_W-1:0]        load_data,
	output logic [mem_pkg::WORD_W-1:0]        rd_data, // qualified by ready
	output logic                              ready,
	output logic                              busy // high through a whole fill
);
	import cache_geom_pkg::*;
	import mem_pkg::*;

	logic                  hit;
	logic                  miss_detected;
	logic                  mem_read;
	logic [ADDR_W-1:0]     mem_read_addr;
	logic                  mem_data_valid;
	logic [WORD_W-1:0]     mem_data;
	logic                  write_data_array;
	logic                  write_tag_array;
	logic [WORD_OFF_W-1:0] fill_word;
	logic [ADDR_W-1:0]     base_addr;

	// ************************************************************
	// lookup side
	// ************************************************************

	cache_tag_array u_tag (
		.clk(clk), .rst(rst), .rd(rd), .busy(busy), .addr(addr),
		.write_tag_array(write_tag_array), .fill_addr(base_addr),
		.hit(hit), .miss_detected(miss_detected)
	);

	cache_data_array u_data (
		.clk(clk), .addr(addr), .write_data_array(write_data_array),
		.fill_addr(base_addr), .fill_word(fill_word), .fill_data(mem_data),
		.rd_data(rd_data)
	);

	assign ready = rd & hit & ~busy; // same cycle on a hit, never during a fill

	// ************************************************************
	// fill side
	// ************************************************************

	cache_fill_fsm u_fsm (
		.clk(clk), .rst(rst), .miss_detected(miss_detected),
		.memory_data_valid(mem_data_valid), .miss_addr(addr), .busy(busy),
		.mem_read(mem_read), .mem_read_addr(mem_read_addr),
		.write_data_array(write_data_array), .cache_write_block_offset(fill_word),
		.write_tag_array(write_tag_array), .base_addr(base_addr)
	);

	main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
		.clk(clk), .rst(rst), .mem_read(mem_read), .mem_read_addr(mem_read_addr),
		.load(load), .load_addr(load_addr), .load_data(load_data),
		.mem_data_valid(mem_data_valid), .mem_data(mem_data)
	);

endmodule

//--- cache_subsystem_asserts.sv
`timescale 1ns/1ns

module cache_subsystem_asserts (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic mem_read,
	input logic write_data_array,
	input logic write_tag_array
);

	logic [3:0] read_cnt; // reads issued so far in the running fill

	// cleared whenever the fsm is idle so each fill counts from zero
	always_ff @(posedge clk) begin
		if (rst || !busy) begin
			read_cnt <= 4'd0;
		end else if (mem_read) begin
			read_cnt <= read_cnt + 4'd1;
		end
	end

	// ************************************************************
	// fill sequencing
	// ************************************************************

	// a requested word comes back later, so the fill has to outlive every read
	a_read_in_fill: assert property (@(posedge clk) disable iff (rst) mem_read |=> busy)
		else $error("fill ended right after a memory read");

	a_tag_one_cycle: assert property (@(posedge clk) disable iff (rst)
		write_tag_array |=> !write_tag_array)
		else $error("tag write held longer than one cycle");

	a_eight_reads: assert property (@(posedge clk) disable iff (rst)
		write_tag_array |-> read_cnt == 4'd8)
		else $error("fill finished without exactly eight reads");

	a_no_ninth_read: assert property (@(posedge clk) disable iff (rst)
		mem_read |-> read_cnt < 4'd8)
		else $error("fill issued a ninth read");

	a_data_in_fill: assert property (@(posedge clk) disable iff (rst)
		write_data_array |-> busy)
		else $error("data array written outside a fill");

endmodule

bind cache_fill_fsm cache_subsystem_asserts u_fill_asserts (
	.clk(clk), .rst(rst), .busy(busy), .mem_read(mem_read),
	.write_data_array(write_data_array), .write_tag_array(write_tag_array)
);

//--- cache_subsystem_tb.sv
`timescale 1ns/1ns

module cache_subsystem_tb;
	import cache_geom_pkg::*;
	import mem_pkg::*;

	localparam int MEM_LATENCY    = 4;
	localparam int NUM_TESTS      = 19;
	localparam int MISS_STALL     = 10 + MEM_LATENCY; // edges from the miss edge to ready
	localparam int STALL_BOUND    = MISS_STALL + 4; // give up a little past a full fill
	localparam int TIMEOUT_CYCLES = MEM_DEPTH + NUM_TESTS * (MEM_LATENCY + 14) + 100;

	// ************************************************************
	// test table  {reset first, expected hit, byte address}
	// ************************************************************

	localparam logic [17:0] TESTS [NUM_TESTS] = '{
		{1'b0, 1'b0, 16'h0126}, // cold miss, set 0x12 tag 0
		{1'b0, 1'b1, 16'h0126}, // same word again
		{1'b0, 1'b1, 16'h0120}, // walk the rest of the block
		{1'b0, 1'b1, 16'h0122},
		{1'b0, 1'b1, 16'h0124},
		{1'b0, 1'b1, 16'h0127}, // odd byte lands on word 3
		{1'b0, 1'b1, 16'h0128},
		{1'b0, 1'b1, 16'h012A},
		{1'b0, 1'b1, 16'h012C},
		{1'b0, 1'b1, 16'h012E},
		{1'b0, 1'b0, 16'h1524}, // set 0x12 tag 5 evicts the first block
		{1'b0, 1'b0, 16'h0126}, // and the first block comes back
		{1'b0, 1'b0, 16'h0340}, // set 0x34
		{1'b0, 1'b0, 16'h2A58}, // set 0x25 tag 0xA
		{1'b0, 1'b1, 16'h0346},
		{1'b0, 1'b1, 16'h2A5E},
		{1'b0, 1'b1, 16'h012C}, // set 0x12 untouched by the others
		{1'b1, 1'b0, 16'h0346}, // reset wiped the valid bits
		{1'b0, 1'b1, 16'h0346}
	};

	logic                  clk;
	logic                  rst;
	logic                  rd;
	logic [ADDR_W-1:0]     addr;
	logic                  load;
	logic [MEM_ADDR_W-1:0] load_addr;
	logic [WORD_W-1:0]     load_data;
	logic [WORD_W-1:0]     rd_data;
	logic                  ready;
	logic                  busy;

	logic [WORD_W-1:0]   shadow [MEM_DEPTH]; // copy of everything preloaded
	logic [TAG_W-1:0]    model_tag [NUM_SETS]; // tag model of the cache
	logic [NUM_SETS-1:0] model_valid;
	int                  error_cnt;
	int                  pass_cnt;
	int                  fail_cnt;
	int                  cycle_cnt = 0;

	cache_subsystem #(.MEM_LATENCY(MEM_LATENCY)) DUT (
		.clk(clk), .rst(rst), .rd(rd), .addr(addr), .load(load),
		.load_addr(load_addr), .load_data(load_data),
		.rd_data(rd_data), .ready(ready), .busy(busy)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	// hard stop in case the DUT never answers
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// fill all of memory with random words, one per cycle through the load port
	task automatic preload_memory;
		logic [31:0] word;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			word = $urandom;
			shadow[i] = word[WORD_W-1:0];
			@(posedge clk);
			load      <= 1'b1;
			load_addr <= i[MEM_ADDR_W-1:0];
			load_data <= word[WORD_W-1:0];
		end
		@(posedge clk);
		load <= 1'b0;
	endtask

	task automatic pulse_reset;
		@(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		model_valid = '0; // every set goes cold again
	endtask

	// ************************************************************
	// one cpu read, held until ready, then checked against the models
	// ************************************************************

	task automatic run_access(input int n, input logic [ADDR_W-1:0] a, input logic exp_hit);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tag;
		logic [WORD_W-1:0]  exp_data;
		logic [WORD_W-1:0]  got;
		logic               model_hit;
		logic               got_ready;
		logic               saw_busy;
		int                 stall;
		int                 exp_stall;
		int                 errs_before;
		idx         = a[INDEX_LSB +: INDEX_W];
		tag         = a[TAG_LSB +: TAG_W];
		model_hit   = model_valid[idx] && (model_tag[idx] == tag);
		exp_data    = shadow[a[MEM_ADDR_W:1]]; // byte bit 0 does not pick a word
		exp_stall   = model_hit ? 0 : MISS_STALL;
		errs_before = error_cnt;
		stall       = 0;
		saw_busy    = 1'b0;
		got         = '0;
		if (model_hit != exp_hit) begin
			$display("test %0d: the table and the tag model disagree on hit or miss", n);
			error_cnt++;
		end
		@(posedge clk);
		rd   <= 1'b1;
		addr <= a;
		// values read here are the ones that settled before this edge
		do begin
			@(posedge clk);
			got_ready = ready;
			if (got_ready) begin
				got = rd_data;
			end else begin
				stall++;
				if (busy) saw_busy = 1'b1;
			end
		end while (!got_ready && stall <= STALL_BOUND);
		rd <= 1'b0;
		// a fill wrongly started by a hit shows busy one edge after ready
		if (got_ready && model_hit) begin
			@(posedge clk);
			if (busy) saw_busy = 1'b1;
		end
		if (!got_ready) begin
			$display("test %0d: ready never came within %0d cycles of the request", n, stall);
			error_cnt++;
		end else begin
			if (stall != exp_stall) begin
				$display("Error %0t: test %0d stalled %0d cycles, expected %0d",
					$time, n, stall, exp_stall);
				error_cnt++;
			end
			if (model_hit && saw_busy) begin
				$display("Error %0t: test %0d busy rose on a hit", $time, n);
				error_cnt++;
			end
			if (!model_hit && !saw_busy) begin
				$display("Error %0t: test %0d miss without busy", $time, n);
				error_cnt++;
			end
			if (got != exp_data) begin
				$display("Error %0t: test %0d addr %h read %h, expected %h",
					$time, n, a, got, exp_data);
				error_cnt++;
			end
		end
		model_valid[idx] = 1'b1; // after the access the block is resident either way
		model_tag[idx]   = tag;
		if (error_cnt == errs_before) pass_cnt++;
		else fail_cnt++;
		$display("test %2d  addr %h  %s  stall %0d  data %h  %s", n, a,
			model_hit ? "hit " : "miss", stall, got, (error_cnt == errs_before) ? "ok" : "bad");
	endtask

	initial begin
		rst       <= 1'b1;
		rd        <= 1'b0;
		addr      <= '0;
		load      <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		error_cnt   = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		model_valid = '0;
		void'($urandom(32'hd9b9851e));
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		preload_memory();
		for (int n = 0; n < NUM_TESTS; n++) begin
			if (TESTS[n][17]) pulse_reset();
			run_access(n, TESTS[n][15:0], TESTS[n][16]);
		end
		$display("tests %0d  passed %0d  failed %0d  errors %0d",
			NUM_TESTS, pass_cnt, fail_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- list.f
cache_geom_pkg.sv
mem_pkg.sv
cache_fill_fsm.sv
cache_tag_array.sv
cache_data_array.sv
main_memory.sv
cache_subsystem.sv
cache_subsystem_asserts.sv
cache_subsystem_tb.sv

//--- Makefile
# Verilator build and run of the cache subsystem testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module cache_subsystem_tb -f list.f -o cache_sim

run: compile
	@out="$$(./obj_dir/cache_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
